// ==== cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath width
`define DATA_W 32

// Register address width
`define REG_W 5

`endif

// ==== cpuPkg.sv ====
package cpuPkg;

  typedef enum logic [2:0] {
    aluAdd  = 3'd0,
    aluSub  = 3'd1,
    aluAnd  = 3'd2,
    aluOr   = 3'd3,
    aluXor  = 3'd4,
    aluSlt  = 3'd5,  // Signed compare
    aluSltu = 3'd6   // Unsigned compare
  } aluOpT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ARM condition field encoding
  typedef enum logic [3:0] {
    condEq = 4'h0,
    condNe = 4'h1,
    condCs = 4'h2,
    condCc = 4'h3,
    condMi = 4'h4,
    condPl = 4'h5,
    condVs = 4'h6,
    condVc = 4'h7,
    condHi = 4'h8,
    condLs = 4'h9,
    condGe = 4'ha,
    condLt = 4'hb,
    condGt = 4'hc,
    condLe = 4'hd,
    condAl = 4'he
  } condT;

  typedef enum logic [1:0] {
    fwdNone  = 2'b00,  // Register file value
    fwdFromW = 2'b01,
    fwdFromM = 2'b10
  } fwdSelT;

  typedef struct packed {
    logic       regWrite;
    logic       memWrite;
    logic       branch;
    logic       jump;       // RISC-V only
    logic       aluSrc;     // Immediate as operand B
    aluOpT      aluOp;
    logic       pcSrc;      // ARM write to PC
    logic [1:0] flagWrite;  // Bit 1 is NZ, bit 0 is CV
    condT       cond;
    logic [1:0] resultSrc;  // 0 ALU, 1 memory, 2 pcPlus4
  } ctrlT;

endpackage

// ==== execIf.sv ====
`include "cpu_params.svh"

interface execIf;
  import cpuPkg::*;

  ctrlT               ctrl;       // Write enables already gated
  logic [`DATA_W-1:0] aluResult;
  logic [`DATA_W-1:0] writeData;  // Store data, forwarded operand B
  logic [`REG_W-1:0]  rd;
  logic [`DATA_W-1:0] pcPlus4;

  modport src (
    output ctrl,
    output aluResult,
    output writeData,
    output rd,
    output pcPlus4
  );

  modport dst (
    input ctrl,
    input aluResult,
    input writeData,
    input rd,
    input pcPlus4
  );

endinterface

// ==== alu.sv ====
`include "cpu_params.svh"

module alu (
  input  logic [`DATA_W-1:0] a,
  input  logic [`DATA_W-1:0] b,
  input  cpuPkg::aluOpT      op,
  output logic [`DATA_W-1:0] result,
  output cpuPkg::flagsT      flags
);
  import cpuPkg::*;

  logic               isSub;
  logic               arith;
  logic [`DATA_W-1:0] bEff;
  logic [`DATA_W:0]   sum;
  logic               ovf;
  logic               signedLt;

  // Compares share the subtractor
  assign isSub = (op == aluSub) || (op == aluSlt) || (op == aluSltu);
  assign arith = (op == aluAdd) || (op == aluSub);
  assign bEff  = isSub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, bEff} + (`DATA_W+1)'(isSub);

  assign ovf = (a[`DATA_W-1] == bEff[`DATA_W-1]) && (sum[`DATA_W-1] != a[`DATA_W-1]);
  assign signedLt = sum[`DATA_W-1] ^ ovf;

  always_comb begin
    case (op)
      aluAdd,
      aluSub:  result = sum[`DATA_W-1:0];
      aluAnd:  result = a & b;
      aluOr:   result = a | b;
      aluXor:  result = a ^ b;
      aluSlt:  result = {{(`DATA_W-1){1'b0}}, signedLt};
      aluSltu: result = {{(`DATA_W-1){1'b0}}, ~sum[`DATA_W]};  // Borrow out
      default: result = '0;
    endcase
  end

  always_comb begin
    flags.n = result[`DATA_W-1];
    flags.z = ~|result;
    flags.c = arith & sum[`DATA_W];  // ARM style, not-borrow on sub
    flags.v = arith & ovf;
  end

  // RISC-V beq relies on this through the zero flag
  aZeroOnEqual: assert final (op != aluSub || flags.z == (a == b))
    else $error("alu: sub zero flag disagrees with operand equality");

endmodule

// ==== condLogic.sv ====
module condLogic (
  input  logic          clk,
  input  logic          arstN,
  input  logic          arm,
  input  logic          flushE,
  input  cpuPkg::ctrlT  ctrl,
  input  cpuPkg::flagsT aluFlags,
  output logic          regWriteOk,
  output logic          memWriteOk,
  output logic          branchTaken
);
  import cpuPkg::*;

  flagsT flagsQ;      // Architectural NZCV
  logic  bubbleQ;     // Execute slot squashed at the last edge
  logic  condEx;
  logic  flagUpdate;

  always_comb begin
    case (ctrl.cond)
      condEq:  condEx = flagsQ.z;
      condNe:  condEx = ~flagsQ.z;
      condCs:  condEx = flagsQ.c;
      condCc:  condEx = ~flagsQ.c;
      condMi:  condEx = flagsQ.n;
      condPl:  condEx = ~flagsQ.n;
      condVs:  condEx = flagsQ.v;
      condVc:  condEx = ~flagsQ.v;
      condHi:  condEx = flagsQ.c & ~flagsQ.z;
      condLs:  condEx = ~flagsQ.c | flagsQ.z;
      condGe:  condEx = (flagsQ.n == flagsQ.v);
      condLt:  condEx = (flagsQ.n != flagsQ.v);
      condGt:  condEx = ~flagsQ.z & (flagsQ.n == flagsQ.v);
      condLe:  condEx = flagsQ.z | (flagsQ.n != flagsQ.v);
      default: condEx = 1'b1;  // AL and the unconditional space
    endcase
  end

  assign flagUpdate = arm & condEx & ~bubbleQ;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flagsQ  <= '0;
      bubbleQ <= 1'b1;
    end else begin
      bubbleQ <= flushE;
      if (flagUpdate && ctrl.flagWrite[1]) begin
        flagsQ.n <= aluFlags.n;
        flagsQ.z <= aluFlags.z;
      end
      if (flagUpdate && ctrl.flagWrite[0]) begin
        flagsQ.c <= aluFlags.c;
        flagsQ.v <= aluFlags.v;
      end
    end
  end

  // RISC-V mode ignores the condition field
  assign regWriteOk  = arm ? (ctrl.regWrite & condEx) : ctrl.regWrite;
  assign memWriteOk  = arm ? (ctrl.memWrite & condEx) : ctrl.memWrite;
  assign branchTaken = flagUpdate & (ctrl.branch | ctrl.pcSrc);

endmodule

// ==== hazardUnit.sv ====
`include "cpu_params.svh"

module hazardUnit (
  input  logic [`REG_W-1:0] rs1E,
  input  logic [`REG_W-1:0] rs2E,
  input  logic [`REG_W-1:0] rdM,
  input  logic [`REG_W-1:0] rdW,
  input  logic              regWriteM,
  input  logic              regWriteW,
  input  logic              redirectE,
  output cpuPkg::fwdSelT    fwdA,
  output cpuPkg::fwdSelT    fwdB,
  output logic              flushE
);
  import cpuPkg::*;

  // Memory stage holds the younger result, so it wins
  function automatic fwdSelT selectSrc(input logic [`REG_W-1:0] rs,
                                       input logic [`REG_W-1:0] dstM,
                                       input logic              weM,
                                       input logic [`REG_W-1:0] dstW,
                                       input logic              weW);
    fwdSelT sel;
    sel = fwdNone;
    if (rs != '0 && rs == dstM && weM) begin
      sel = fwdFromM;
    end else if (rs != '0 && rs == dstW && weW) begin
      sel = fwdFromW;
    end
    return sel;
  endfunction

  always_comb begin
    fwdA = selectSrc(rs1E, rdM, regWriteM, rdW, regWriteW);
    fwdB = selectSrc(rs2E, rdM, regWriteM, rdW, regWriteW);
  end

  // Kill the wrong-path instruction now in decode
  assign flushE = redirectE;

endmodule

// ==== stageE.sv ====
`include "cpu_params.svh"

module stageE (
  input  logic               clk,
  input  logic               arstN,
  input  logic               arm,
  input  logic               flushE,
  input  logic [`DATA_W-1:0] rd1D,
  input  logic [`DATA_W-1:0] rd2D,
  input  logic [`DATA_W-1:0] immExtD,
  input  logic [`DATA_W-1:0] pcD,
  input  logic [`DATA_W-1:0] pcPlus4D,
  input  logic [`REG_W-1:0]  rs1D,
  input  logic [`REG_W-1:0]  rs2D,
  input  logic [`REG_W-1:0]  rdD,
  input  cpuPkg::ctrlT       ctrlD,
  input  cpuPkg::fwdSelT     fwdA,
  input  cpuPkg::fwdSelT     fwdB,
  input  logic [`DATA_W-1:0] aluResultM,
  input  logic [`DATA_W-1:0] resultW,
  output logic [`REG_W-1:0]  rs1E,
  output logic [`REG_W-1:0]  rs2E,
  output logic               redirectE,
  output logic [`DATA_W-1:0] pcTargetE,
  execIf.src                 ex
);
  import cpuPkg::*;

  ctrlT               ctrlE;
  logic [`REG_W-1:0]  rdE;
  logic [`DATA_W-1:0] rd1E;
  logic [`DATA_W-1:0] rd2E;
  logic [`DATA_W-1:0] immExtE;
  logic [`DATA_W-1:0] pcE;
  logic [`DATA_W-1:0] pcPlus4E;
  logic [`DATA_W-1:0] srcA;
  logic [`DATA_W-1:0] srcB;       // Forwarded rs2, also the store data
  logic [`DATA_W-1:0] aluB;
  logic [`DATA_W-1:0] aluResultE;
  flagsT              aluFlagsE;
  logic               regWriteOk;
  logic               memWriteOk;
  logic               branchTaken;

  function automatic logic [`DATA_W-1:0] pickOperand(input fwdSelT            sel,
                                                     input logic [`DATA_W-1:0] regVal,
                                                     input logic [`DATA_W-1:0] fromM,
                                                     input logic [`DATA_W-1:0] fromW);
    case (sel)
      fwdFromM: return fromM;
      fwdFromW: return fromW;
      default:  return regVal;
    endcase
  endfunction

  // Decode/execute register, a flush turns it into a bubble
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlE <= '0;
      rs1E  <= '0;
      rs2E  <= '0;
      rdE   <= '0;
    end else if (flushE) begin
      ctrlE <= '0;
      rs1E  <= '0;
      rs2E  <= '0;
      rdE   <= '0;
    end else begin
      ctrlE <= ctrlD;
      rs1E  <= rs1D;
      rs2E  <= rs2D;
      rdE   <= rdD;
    end
  end

  always_ff @(posedge clk) begin
    rd1E     <= rd1D;
    rd2E     <= rd2D;
    immExtE  <= immExtD;
    pcE      <= pcD;
    pcPlus4E <= pcPlus4D;
  end

  always_comb begin
    srcA = pickOperand(fwdA, rd1E, aluResultM, resultW);
    srcB = pickOperand(fwdB, rd2E, aluResultM, resultW);
    aluB = ctrlE.aluSrc ? immExtE : srcB;
  end

  alu uAlu (
    .a      (srcA),
    .b      (aluB),
    .op     (ctrlE.aluOp),
    .result (aluResultE),
    .flags  (aluFlagsE)
  );

  condLogic uCondLogic (
    .clk         (clk),
    .arstN       (arstN),
    .arm         (arm),
    .flushE      (flushE),
    .ctrl        (ctrlE),
    .aluFlags    (aluFlagsE),
    .regWriteOk  (regWriteOk),
    .memWriteOk  (memWriteOk),
    .branchTaken (branchTaken)
  );

  // ARM computes its target in the ALU
  assign pcTargetE = arm ? aluResultE : pcE + immExtE;
  assign redirectE = arm ? branchTaken : (ctrlE.jump | (ctrlE.branch & aluFlagsE.z));

  always_comb begin
    ex.ctrl          = ctrlE;
    ex.ctrl.regWrite = regWriteOk;
    ex.ctrl.memWrite = memWriteOk;
  end

  assign ex.aluResult = aluResultE;
  assign ex.writeData = srcB;
  assign ex.rd        = rdE;
  assign ex.pcPlus4   = pcPlus4E;

  aFwdALegal: assert property (@(posedge clk) disable iff (!arstN) fwdA != 2'b11)
    else $error("stageE: hazard unit drove reserved forward select");

endmodule

// ==== stageMW.sv ====
`include "cpu_params.svh"

module stageMW (
  input  logic               clk,
  input  logic               arstN,
  execIf.dst                 ex,
  output logic               memWriteM,
  output logic [`DATA_W-1:0] aluResultM,
  output logic [`DATA_W-1:0] writeDataM,
  output logic [`REG_W-1:0]  rdM,
  output logic               regWriteM,
  output logic               regWriteW,
  output logic [`REG_W-1:0]  rdW,
  output logic [`DATA_W-1:0] resultW
);
  import cpuPkg::*;

  ctrlT               ctrlM;
  logic [`DATA_W-1:0] pcPlus4M;
  logic [1:0]         resultSrcW;
  logic [`DATA_W-1:0] aluResultW;
  logic [`DATA_W-1:0] pcPlus4W;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlM      <= '0;
      rdM        <= '0;
      regWriteW  <= 1'b0;
      rdW        <= '0;
      resultSrcW <= '0;
    end else begin
      ctrlM      <= ex.ctrl;
      rdM        <= ex.rd;
      regWriteW  <= ctrlM.regWrite;
      rdW        <= rdM;
      resultSrcW <= ctrlM.resultSrc;
    end
  end

  always_ff @(posedge clk) begin
    aluResultM <= ex.aluResult;
    writeDataM <= ex.writeData;
    pcPlus4M   <= ex.pcPlus4;
    aluResultW <= aluResultM;  // Also stands in for load data
    pcPlus4W   <= pcPlus4M;
  end

  assign memWriteM = ctrlM.memWrite;
  assign regWriteM = ctrlM.regWrite;

  // Link value for jumps
  assign resultW = (resultSrcW == 2'd2) ? pcPlus4W : aluResultW;

  aResultSrcLegal: assert property (@(posedge clk) disable iff (!arstN)
                                    regWriteW |-> resultSrcW != 2'd3)
    else $error("stageMW: writeback with reserved result source");

endmodule

// ==== execCore.sv ====
`include "cpu_params.svh"

module execCore (
  input  logic               clk,
  input  logic               arstN,
  input  logic               arm,
  input  logic [`DATA_W-1:0] rd1D,
  input  logic [`DATA_W-1:0] rd2D,
  input  logic [`DATA_W-1:0] immExtD,
  input  logic [`DATA_W-1:0] pcD,
  input  logic [`DATA_W-1:0] pcPlus4D,
  input  logic [`REG_W-1:0]  rs1D,
  input  logic [`REG_W-1:0]  rs2D,
  input  logic [`REG_W-1:0]  rdD,
  input  cpuPkg::ctrlT       ctrlD,
  output logic               redirectE,
  output logic [`DATA_W-1:0] pcTargetE,
  output logic               memWriteM,
  output logic [`DATA_W-1:0] aluResultM,
  output logic [`DATA_W-1:0] writeDataM,
  output logic               regWriteW,
  output logic [`REG_W-1:0]  rdW,
  output logic [`DATA_W-1:0] resultW
);
  import cpuPkg::*;

  fwdSelT            fwdA;
  fwdSelT            fwdB;
  logic              flushE;
  logic [`REG_W-1:0] rs1E;
  logic [`REG_W-1:0] rs2E;
  logic [`REG_W-1:0] rdM;
  logic              regWriteM;

  execIf exBus ();  // Execute to memory stage

  stageE uStageE (
    .clk        (clk),
    .arstN      (arstN),
    .arm        (arm),
    .flushE     (flushE),
    .rd1D       (rd1D),
    .rd2D       (rd2D),
    .immExtD    (immExtD),
    .pcD        (pcD),
    .pcPlus4D   (pcPlus4D),
    .rs1D       (rs1D),
    .rs2D       (rs2D),
    .rdD        (rdD),
    .ctrlD      (ctrlD),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .aluResultM (aluResultM),
    .resultW    (resultW),
    .rs1E       (rs1E),
    .rs2E       (rs2E),
    .redirectE  (redirectE),
    .pcTargetE  (pcTargetE),
    .ex         (exBus.src)
  );

  stageMW uStageMW (
    .clk        (clk),
    .arstN      (arstN),
    .ex         (exBus.dst),
    .memWriteM  (memWriteM),
    .aluResultM (aluResultM),
    .writeDataM (writeDataM),
    .rdM        (rdM),
    .regWriteM  (regWriteM),
    .regWriteW  (regWriteW),
    .rdW        (rdW),
    .resultW    (resultW)
  );

  hazardUnit uHazardUnit (
    .rs1E      (rs1E),
    .rs2E      (rs2E),
    .rdM       (rdM),
    .rdW       (rdW),
    .regWriteM (regWriteM),
    .regWriteW (regWriteW),
    .redirectE (redirectE),
    .fwdA      (fwdA),
    .fwdB      (fwdB),
    .flushE    (flushE)
  );

endmodule

// ==== tb_execCore.sv ====
`include "cpu_params.svh"

module tb_execCore;
  timeunit 1ns;
  timeprecision 100ps;
  import cpuPkg::*;

  // Instructions per test with drains
  localparam int NumInstr = 13 + 15 + 10 + 17 + 11;

  logic               clk = 1'b0;
  logic               arstN;
  logic               arm;
  logic [`DATA_W-1:0] rd1D;
  logic [`DATA_W-1:0] rd2D;
  logic [`DATA_W-1:0] immExtD;
  logic [`DATA_W-1:0] pcD;
  logic [`DATA_W-1:0] pcPlus4D;
  logic [`REG_W-1:0]  rs1D;
  logic [`REG_W-1:0]  rs2D;
  logic [`REG_W-1:0]  rdD;
  ctrlT               ctrlD;
  logic               redirectE;
  logic [`DATA_W-1:0] pcTargetE;
  logic               memWriteM;
  logic [`DATA_W-1:0] aluResultM;
  logic [`DATA_W-1:0] writeDataM;
  logic               regWriteW;
  logic [`REG_W-1:0]  rdW;
  logic [`DATA_W-1:0] resultW;

  integer             seed;
  int                 errors;
  int                 testsRun;
  int                 testsFailed;
  int                 cycle;
  logic [`DATA_W-1:0] archRegs [32];  // Program-order values
  logic [`DATA_W-1:0] rfRegs [32];    // What a register file holds after writeback
  flagsT              archFlags;
  // Expected outputs indexed by cycle modulo 4
  logic               expRedir [4];
  logic [`DATA_W-1:0] expTarget [4];
  logic               expMem [4];
  logic               expMemChk [4];  // Memory stage holds a real instruction
  logic [`DATA_W-1:0] expAluM [4];
  logic [`DATA_W-1:0] expWrData [4];
  logic               expRegW [4];
  logic [`REG_W-1:0]  expRd [4];
  logic [`DATA_W-1:0] expRes [4];

  execCore u_execCore (.*);

  always #50 clk = ~clk;

  function automatic ctrlT mkCtrl(input logic rw, input logic mw, input logic br,
                                  input logic jp, input logic src, input aluOpT op,
                                  input logic [1:0] fw, input condT cond,
                                  input logic [1:0] rs);
    ctrlT c;
    c = '0;
    c.regWrite  = rw;
    c.memWrite  = mw;
    c.branch    = br;
    c.jump      = jp;
    c.aluSrc    = src;
    c.aluOp     = op;
    c.flagWrite = fw;
    c.cond      = cond;
    c.resultSrc = rs;
    return c;
  endfunction

  function automatic ctrlT regOp(input aluOpT op);
    return mkCtrl(1, 0, 0, 0, 0, op, 2'b00, condAl, 2'd0);
  endfunction

  function automatic ctrlT condOp(input aluOpT op, input condT cond);
    return mkCtrl(1, 0, 0, 0, 0, op, 2'b00, cond, 2'd0);
  endfunction

  // ARM condition rules on NZCV
  function automatic logic condHolds(input condT cond, input flagsT f);
    case (cond)
      condEq:  return f.z;
      condNe:  return !f.z;
      condCs:  return f.c;
      condCc:  return !f.c;
      condMi:  return f.n;
      condPl:  return !f.n;
      condVs:  return f.v;
      condVc:  return !f.v;
      condHi:  return f.c && !f.z;
      condLs:  return !f.c || f.z;
      condGe:  return f.n == f.v;
      condLt:  return f.n != f.v;
      condGt:  return !f.z && (f.n == f.v);
      condLe:  return f.z || (f.n != f.v);
      default: return 1'b1;
    endcase
  endfunction

  task automatic refAlu(input aluOpT op, input logic [`DATA_W-1:0] a,
                        input logic [`DATA_W-1:0] b, output logic [`DATA_W-1:0] res,
                        output flagsT f);
    logic [`DATA_W:0] wide;
    f = '0;
    case (op)
      aluAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        res  = wide[`DATA_W-1:0];
        f.c  = wide[`DATA_W];
        f.v  = (a[`DATA_W-1] == b[`DATA_W-1]) && (res[`DATA_W-1] != a[`DATA_W-1]);
      end
      aluSub: begin
        res = a - b;
        f.c = (a >= b);  // Carry means no borrow
        f.v = (a[`DATA_W-1] != b[`DATA_W-1]) && (res[`DATA_W-1] != a[`DATA_W-1]);
      end
      aluAnd:  res = a & b;
      aluOr:   res = a | b;
      aluXor:  res = a ^ b;
      aluSlt:  res = ($signed(a) < $signed(b)) ? 1 : 0;
      aluSltu: res = (a < b) ? 1 : 0;
      default: res = '0;
    endcase
    f.n = res[`DATA_W-1];
    f.z = (res == '0);
  endtask

  task automatic logMismatch(input string name, input logic [`DATA_W-1:0] expV,
                             input logic [`DATA_W-1:0] gotV);
    errors++;
    $display("Fail at %0d ns: %s expected %0h, got %0h", $time, name, expV, gotV);
  endtask

  task automatic setReg(input int r, input logic [`DATA_W-1:0] v);
    archRegs[r] = v;
    rfRegs[r]   = v;
  endtask

  // Check older instructions then drive a new one
  task automatic issue(input ctrlT c, input int rs1, input int rs2, input int rd,
                       input logic [`DATA_W-1:0] imm, input logic [`DATA_W-1:0] pc);
    int                 s;
    logic               squash;
    logic               pass;
    logic               we;
    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] res;
    logic [`DATA_W-1:0] wbVal;
    flagsT              f;
    @(negedge clk);
    cycle++;
    s = cycle % 4;
    if (redirectE !== expRedir[s]) logMismatch("redirectE", expRedir[s], redirectE);
    if (expRedir[s] && pcTargetE !== expTarget[s]) begin
      logMismatch("pcTargetE", expTarget[s], pcTargetE);
    end
    if (memWriteM !== expMem[s]) logMismatch("memWriteM", expMem[s], memWriteM);
    if (expMemChk[s] && aluResultM !== expAluM[s]) begin
      logMismatch("aluResultM", expAluM[s], aluResultM);
    end
    if (expMemChk[s] && writeDataM !== expWrData[s]) begin
      logMismatch("writeDataM", expWrData[s], writeDataM);
    end
    if (regWriteW !== expRegW[s]) logMismatch("regWriteW", expRegW[s], regWriteW);
    if (expRegW[s] && rdW !== expRd[s]) logMismatch("rdW", expRd[s], rdW);
    if (expRegW[s] && resultW !== expRes[s]) logMismatch("resultW", expRes[s], resultW);
    if (expRegW[s] && expRd[s] != 0) rfRegs[expRd[s]] = expRes[s];  // Write before read
    squash   = expRedir[s];  // Wrong path after a taken redirect
    rd1D     = rfRegs[rs1];
    rd2D     = rfRegs[rs2];
    immExtD  = imm;
    pcD      = pc;
    pcPlus4D = pc + 4;
    rs1D     = rs1[`REG_W-1:0];
    rs2D     = rs2[`REG_W-1:0];
    rdD      = rd[`REG_W-1:0];
    ctrlD    = c;
    opB = c.aluSrc ? imm : archRegs[rs2];
    refAlu(c.aluOp, archRegs[rs1], opB, res, f);
    pass  = !squash && (!arm || condHolds(c.cond, archFlags));
    we    = pass && c.regWrite;
    wbVal = (c.resultSrc == 2'd2) ? pc + 4 : res;
    expRedir[(cycle + 1) % 4]  = pass && (arm ? c.branch
                                              : (c.jump || (c.branch && res == '0)));
    expTarget[(cycle + 1) % 4] = arm ? res : pc + imm;
    expMem[(cycle + 2) % 4]    = pass && c.memWrite;
    expMemChk[(cycle + 2) % 4] = !squash;
    expAluM[(cycle + 2) % 4]   = res;
    expWrData[(cycle + 2) % 4] = archRegs[rs2];
    expRegW[(cycle + 3) % 4]   = we;
    expRd[(cycle + 3) % 4]     = rd[`REG_W-1:0];
    expRes[(cycle + 3) % 4]    = wbVal;
    if (we && rd != 0) archRegs[rd] = wbVal;
    if (arm && pass && c.flagWrite[1]) begin
      archFlags.n = f.n;
      archFlags.z = f.z;
    end
    if (arm && pass && c.flagWrite[0]) begin
      archFlags.c = f.c;
      archFlags.v = f.v;
    end
  endtask

  task automatic nop();
    issue('0, 0, 0, 0, 0, 0);
  endtask

  task automatic drain();
    repeat (3) nop();
  endtask

  task automatic reportTest(input string name, input int errsBefore);
    testsRun++;
    if (errors == errsBefore) begin
      $display("Test %s: passed", name);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errors - errsBefore);
    end
  endtask

  task automatic resetCheck();
    int e0;
    e0 = errors;
    repeat (2) begin
      @(negedge clk);
      if (regWriteW !== 1'b0) logMismatch("regWriteW", 0, regWriteW);
      if (memWriteM !== 1'b0) logMismatch("memWriteM", 0, memWriteM);
      if (redirectE !== 1'b0) logMismatch("redirectE", 0, redirectE);
    end
    arstN = 1'b1;
    reportTest("reset", e0);
  endtask

  task automatic aluOps();
    int e0;
    e0 = errors;
    arm = 1'b0;
    for (int i = 0; i < 10; i++) begin
      setReg(i + 1, $random(seed));
      setReg(i + 11, $random(seed));
      issue(mkCtrl(1, 0, 0, 0, i % 2, aluOpT'(i % 7), 2'b00, condAl, 2'd0),
            i + 1, i + 11, i + 21, $random(seed), 0);
    end
    drain();
    reportTest("aluOps", e0);
  endtask

  task automatic forwarding();
    int e0;
    e0 = errors;
    arm = 1'b0;
    setReg(1, $random(seed));
    setReg(2, $random(seed));
    issue(regOp(aluAdd), 1, 2, 3, 0, 0);
    issue(regOp(aluSub), 3, 1, 4, 0, 0);  // Distance one
    issue(regOp(aluXor), 2, 3, 5, 0, 0);  // Distance two
    issue(regOp(aluOr), 4, 5, 6, 0, 0);
    issue(mkCtrl(1, 0, 0, 0, 1, aluAdd, 2'b00, condAl, 2'd0), 6, 0, 3, 32'h123, 0);
    issue(regOp(aluAdd), 3, 3, 7, 0, 0);
    nop();
    issue(regOp(aluAnd), 7, 6, 8, 0, 0);
    issue(regOp(aluAdd), 3, 7, 9, 0, 0);  // Both from the register file
    issue(mkCtrl(1, 0, 0, 0, 1, aluAdd, 2'b00, condAl, 2'd0), 1, 0, 10, 32'h10, 0);
    issue(regOp(aluAdd), 10, 2, 10, 0, 0);
    issue(regOp(aluAdd), 10, 10, 11, 0, 0);  // Memory stage must win
    drain();
    reportTest("forwarding", e0);
  endtask

  task automatic riscvRedirect();
    int                 e0;
    logic [`DATA_W-1:0] v;
    e0 = errors;
    arm = 1'b0;
    v = $random(seed);
    setReg(1, v);
    setReg(2, v);
    setReg(3, v ^ 32'h8);
    issue(mkCtrl(0, 0, 1, 0, 0, aluSub, 2'b00, condAl, 2'd0), 1, 2, 0, 32'h40, 32'h100);
    issue(regOp(aluAdd), 1, 2, 12, 0, 32'h104);  // Squashed
    issue(mkCtrl(0, 0, 1, 0, 0, aluSub, 2'b00, condAl, 2'd0), 1, 3, 0, 32'h20, 32'h200);
    issue(regOp(aluAdd), 1, 3, 13, 0, 32'h204);
    issue(mkCtrl(1, 0, 0, 1, 0, aluAdd, 2'b00, condAl, 2'd2), 0, 0, 14, 32'h80, 32'h300);
    issue(regOp(aluAdd), 1, 2, 15, 0, 32'h304);  // Squashed
    issue(regOp(aluAdd), 14, 1, 16, 0, 32'h380);  // Link value from writeback
    drain();
    reportTest("riscvRedirect", e0);
  endtask

  task automatic armConditional();
    int                 e0;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    e0 = errors;
    arm = 1'b1;
    for (int r = 0; r < 2; r++) begin
      a = $random(seed);
      b = (r == 1) ? a : $random(seed);
      setReg(1, a);
      setReg(2, b);
      issue(mkCtrl(1, 0, 0, 0, 0, aluSub, 2'b11, condAl, 2'd0), 1, 2, 20, 0, 0);
      issue(condOp(aluAdd, condEq), 1, 2, 21, 0, 0);
      issue(condOp(aluAdd, condNe), 1, 2, 22, 0, 0);
      issue(condOp(aluAdd, condLt), 1, 2, 23, 0, 0);
      issue(condOp(aluAdd, condGe), 1, 2, 24, 0, 0);
      issue(mkCtrl(0, 1, 0, 0, 1, aluAdd, 2'b00, condEq, 2'd0), 1, 2, 0, 32'h10, 0);
      issue(mkCtrl(0, 1, 0, 0, 1, aluAdd, 2'b00, condNe, 2'd0), 1, 2, 0, 32'h14, 0);
    end
    drain();
    reportTest("armConditional", e0);
  endtask

  task automatic armBranch();
    int                 e0;
    logic [`DATA_W-1:0] v;
    e0 = errors;
    arm = 1'b1;
    v = $random(seed);
    setReg(1, v);
    setReg(2, v);
    setReg(3, ~v);
    setReg(25, 32'h1000);  // Branch base
    issue(mkCtrl(0, 0, 0, 0, 0, aluSub, 2'b11, condAl, 2'd0), 1, 2, 0, 0, 0);
    issue(mkCtrl(0, 0, 1, 0, 1, aluAdd, 2'b00, condEq, 2'd0), 25, 0, 0, 32'h20, 0);
    issue(condOp(aluAdd, condAl), 1, 2, 26, 0, 0);  // Squashed
    issue(mkCtrl(0, 0, 1, 0, 1, aluAdd, 2'b00, condNe, 2'd0), 25, 0, 0, 32'h40, 0);
    issue(condOp(aluAdd, condAl), 1, 2, 27, 0, 0);
    issue(mkCtrl(0, 0, 0, 0, 0, aluSub, 2'b11, condAl, 2'd0), 1, 3, 0, 0, 0);
    issue(mkCtrl(0, 0, 1, 0, 1, aluAdd, 2'b00, condNe, 2'd0), 25, 0, 0, 32'h60, 0);
    issue(condOp(aluAdd, condAl), 1, 2, 28, 0, 0);  // Squashed
    drain();
    reportTest("armBranch", e0);
  endtask

  initial begin
    seed        = 32'h5a94;
    arstN       = 1'b0;
    arm         = 1'b0;
    rd1D        = '0;
    rd2D        = '0;
    immExtD     = '0;
    pcD         = '0;
    pcPlus4D    = '0;
    rs1D        = '0;
    rs2D        = '0;
    rdD         = '0;
    ctrlD       = '0;
    errors      = 0;
    testsRun    = 0;
    testsFailed = 0;
    cycle       = 0;
    archFlags   = '0;
    for (int i = 0; i < 4; i++) begin
      expRedir[i]  = 1'b0;
      expTarget[i] = '0;
      expMem[i]    = 1'b0;
      expMemChk[i] = 1'b0;
      expAluM[i]   = '0;
      expWrData[i] = '0;
      expRegW[i]   = 1'b0;
      expRd[i]     = '0;
      expRes[i]    = '0;
    end
    setReg(0, '0);
    for (int i = 1; i < 32; i++) setReg(i, $random(seed));
    resetCheck();
    aluOps();
    forwarding();
    riscvRedirect();
    armConditional();
    armBranch();
    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog allows one clock period per instruction plus slack
  initial begin
    #((NumInstr + 10) * 100);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+.
cpuPkg.sv
execIf.sv
alu.sv
condLogic.sv
hazardUnit.sv
stageE.sv
stageMW.sv
execCore.sv
tb_execCore.sv
